// File: rtl/decode_defs.svh
// ======================================================================
// widths, register count, opcode and funct3/funct7 encodings
// ======================================================================
`ifndef DECODE_DEFS_SVH
`define DECODE_DEFS_SVH

`define XLEN        32
`define REG_ADDR_W  5
`define NUM_REGS    32
`define SHAMT_W     5

`define OPC_OP      7'b0110011
`define OPC_OP_IMM  7'b0010011
`define OPC_LOAD    7'b0000011
`define OPC_STORE   7'b0100011
`define OPC_BRANCH  7'b1100011
`define OPC_JAL     7'b1101111
`define OPC_JALR    7'b1100111
`define OPC_LUI     7'b0110111
`define OPC_AUIPC   7'b0010111

`define FUNCT7_BASE   7'b0000000
`define FUNCT7_ALT    7'b0100000     // sub, sra, srai
`define FUNCT7_MULDIV 7'b0000001

`define F3_ADD      3'd0
`define F3_SLL      3'd1
`define F3_SLT      3'd2
`define F3_SLTU     3'd3
`define F3_XOR      3'd4
`define F3_SR       3'd5             // srl or sra by funct7
`define F3_OR       3'd6
`define F3_AND      3'd7

`define F3_BEQ      3'd0
`define F3_BNE      3'd1
`define F3_BLT      3'd4
`define F3_BGE      3'd5
`define F3_BLTU     3'd6
`define F3_BGEU     3'd7

`define F3_B        3'd0
`define F3_H        3'd1
`define F3_W        3'd2
`define F3_BU       3'd4
`define F3_HU       3'd5

`define F3_JALR     3'd0

`define F3_MUL      3'd0
`define F3_MULH     3'd1
`define F3_MULHSU   3'd2
`define F3_MULHU    3'd3
`define F3_DIV      3'd4
`define F3_DIVU     3'd5
`define F3_REM      3'd6
`define F3_REMU     3'd7

`endif

// File: rtl/decode_pkg.sv
// ======================================================================
// unit, operation and immediate format enums
// instruction word with its R, I, S, B, U and J views
// ======================================================================
`include "decode_defs.svh"

package decode_pkg;

    typedef enum logic [2:0] {
        UNIT_ALU    = 3'd0,
        UNIT_MEM    = 3'd1,
        UNIT_BRANCH = 3'd2,
        UNIT_MUL    = 3'd3,
        UNIT_DIV    = 3'd4
    } unit_e;

    // one code per kept instruction
    typedef enum logic [5:0] {
        OP_ADD = 6'd0, OP_SUB, OP_SLL, OP_SLT, OP_SLTU,
        OP_XOR, OP_SRL, OP_SRA, OP_OR, OP_AND,
        OP_ADDI, OP_SLTI, OP_SLTIU, OP_XORI, OP_ORI,
        OP_ANDI, OP_SLLI, OP_SRLI, OP_SRAI,
        OP_LUI, OP_AUIPC,
        OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU,
        OP_SB, OP_SH, OP_SW,
        OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
        OP_JAL, OP_JALR,
        OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU,
        OP_DIV, OP_DIVU, OP_REM, OP_REMU
    } op_e;

    typedef enum logic [2:0] {
        IMM_NONE  = 3'd0,
        IMM_I     = 3'd1,
        IMM_S     = 3'd2,
        IMM_B     = 3'd3,
        IMM_U     = 3'd4,
        IMM_J     = 3'd5,
        IMM_SHAMT = 3'd6
    } imm_fmt_e;

    typedef struct packed {
        logic [6:0]             funct7;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [2:0]             funct3;
        logic [`REG_ADDR_W-1:0] rd;
        logic [6:0]             opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]            imm_11_0;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [2:0]             funct3;
        logic [`REG_ADDR_W-1:0] rd;
        logic [6:0]             opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0]             imm_11_5;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [2:0]             funct3;
        logic [4:0]             imm_4_0;
        logic [6:0]             opcode;
    } s_fmt_t;

    typedef struct packed {
        logic                   imm_12;
        logic [5:0]             imm_10_5;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [2:0]             funct3;
        logic [3:0]             imm_4_1;
        logic                   imm_11;
        logic [6:0]             opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0]            imm_31_12;
        logic [`REG_ADDR_W-1:0] rd;
        logic [6:0]             opcode;
    } u_fmt_t;

    typedef struct packed {
        logic                   imm_20;
        logic [9:0]             imm_10_1;
        logic                   imm_11;
        logic [7:0]             imm_19_12;
        logic [`REG_ADDR_W-1:0] rd;
        logic [6:0]             opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        u_fmt_t u_fmt;
        j_fmt_t j_fmt;
    } instr_u;

endpackage

// File: rtl/op_decoder.sv
// ======================================================================
// opcode, funct3 and funct7 decode into unit, operation,
// immediate format and illegal flag
// ======================================================================
`include "decode_defs.svh"

module op_decoder import decode_pkg::*; (
    input  instr_u   instr_i,
    output unit_e    unit_o,
    output op_e      op_o,
    output imm_fmt_e imm_fmt_o,
    output logic     illegal_o
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       bad;

    assign opcode = instr_i.r_fmt.opcode;
    assign funct3 = instr_i.r_fmt.funct3;
    assign funct7 = instr_i.r_fmt.funct7;

    // base alu operation, register or immediate flavour
    function automatic op_e alu_op(input logic [2:0] f3, input logic use_imm);
        op_e op;
        op = OP_ADD;
        case (f3)
            `F3_ADD:  op = use_imm ? OP_ADDI  : OP_ADD;
            `F3_SLL:  op = use_imm ? OP_SLLI  : OP_SLL;
            `F3_SLT:  op = use_imm ? OP_SLTI  : OP_SLT;
            `F3_SLTU: op = use_imm ? OP_SLTIU : OP_SLTU;
            `F3_XOR:  op = use_imm ? OP_XORI  : OP_XOR;
            `F3_SR:   op = use_imm ? OP_SRLI  : OP_SRL;
            `F3_OR:   op = use_imm ? OP_ORI   : OP_OR;
            `F3_AND:  op = use_imm ? OP_ANDI  : OP_AND;
            default:  op = OP_ADD;
        endcase
        return op;
    endfunction

    always_comb begin
        unit_o    = UNIT_ALU;
        op_o      = OP_ADD;
        imm_fmt_o = IMM_NONE;
        bad       = 1'b0;
        case (opcode)
            `OPC_OP: begin
                case (funct7)
                    `FUNCT7_BASE: op_o = alu_op(funct3, 1'b0);
                    `FUNCT7_ALT: begin
                        if (funct3 == `F3_ADD) begin
                            op_o = OP_SUB;
                        end else if (funct3 == `F3_SR) begin
                            op_o = OP_SRA;
                        end else begin
                            bad = 1'b1;
                        end
                    end
                    `FUNCT7_MULDIV: begin
                        unit_o = funct3[2] ? UNIT_DIV : UNIT_MUL;  // upper half is div/rem
                        case (funct3)
                            `F3_MUL:    op_o = OP_MUL;
                            `F3_MULH:   op_o = OP_MULH;
                            `F3_MULHSU: op_o = OP_MULHSU;
                            `F3_MULHU:  op_o = OP_MULHU;
                            `F3_DIV:    op_o = OP_DIV;
                            `F3_DIVU:   op_o = OP_DIVU;
                            `F3_REM:    op_o = OP_REM;
                            `F3_REMU:   op_o = OP_REMU;
                        endcase
                    end
                    default: bad = 1'b1;
                endcase
            end
            `OPC_OP_IMM: begin
                op_o      = alu_op(funct3, 1'b1);
                imm_fmt_o = IMM_I;
                if (funct3 == `F3_SLL || funct3 == `F3_SR) begin
                    imm_fmt_o = IMM_SHAMT;
                    if (funct3 == `F3_SR && funct7 == `FUNCT7_ALT) begin
                        op_o = OP_SRAI;
                    end else if (funct7 != `FUNCT7_BASE) begin
                        bad = 1'b1;  // upper imm bits must be zero
                    end
                end
            end
            `OPC_LOAD: begin
                unit_o    = UNIT_MEM;
                imm_fmt_o = IMM_I;
                case (funct3)
                    `F3_B:   op_o = OP_LB;
                    `F3_H:   op_o = OP_LH;
                    `F3_W:   op_o = OP_LW;
                    `F3_BU:  op_o = OP_LBU;
                    `F3_HU:  op_o = OP_LHU;
                    default: bad = 1'b1;
                endcase
            end
            `OPC_STORE: begin
                unit_o    = UNIT_MEM;
                imm_fmt_o = IMM_S;
                case (funct3)
                    `F3_B:   op_o = OP_SB;
                    `F3_H:   op_o = OP_SH;
                    `F3_W:   op_o = OP_SW;
                    default: bad = 1'b1;
                endcase
            end
            `OPC_BRANCH: begin
                unit_o    = UNIT_BRANCH;
                imm_fmt_o = IMM_B;
                case (funct3)
                    `F3_BEQ:  op_o = OP_BEQ;
                    `F3_BNE:  op_o = OP_BNE;
                    `F3_BLT:  op_o = OP_BLT;
                    `F3_BGE:  op_o = OP_BGE;
                    `F3_BLTU: op_o = OP_BLTU;
                    `F3_BGEU: op_o = OP_BGEU;
                    default:  bad = 1'b1;
                endcase
            end
            `OPC_JAL: begin
                unit_o    = UNIT_BRANCH;
                op_o      = OP_JAL;
                imm_fmt_o = IMM_J;
            end
            `OPC_JALR: begin
                unit_o    = UNIT_BRANCH;
                op_o      = OP_JALR;
                imm_fmt_o = IMM_I;
                bad       = (funct3 != `F3_JALR);
            end
            `OPC_LUI: begin
                op_o      = OP_LUI;
                imm_fmt_o = IMM_U;
            end
            `OPC_AUIPC: begin
                op_o      = OP_AUIPC;
                imm_fmt_o = IMM_U;
            end
            default: bad = 1'b1;
        endcase
        if (bad) begin  // illegal words look like a harmless add
            unit_o    = UNIT_ALU;
            op_o      = OP_ADD;
            imm_fmt_o = IMM_NONE;
        end
    end

    assign illegal_o = bad;

    // mul/div units are reachable only from an OP word with the M funct7
    always_comb begin
        assert final (!(unit_o == UNIT_MUL || unit_o == UNIT_DIV) ||
                      (opcode == `OPC_OP && funct7 == `FUNCT7_MULDIV))
            else $error("mul/div unit selected without MULDIV funct7");
    end

endmodule

// File: rtl/imm_gen.sv
// ======================================================================
// immediate and shift amount generation per decoded format
// ======================================================================
`include "decode_defs.svh"

module imm_gen import decode_pkg::*; (
    input  instr_u              instr_i,
    input  imm_fmt_e            fmt_i,
    output logic [`XLEN-1:0]    imm_o,
    output logic [`SHAMT_W-1:0] shamt_o
);

    always_comb begin
        case (fmt_i)
            IMM_I, IMM_SHAMT: begin
                imm_o = {{(`XLEN-12){instr_i.i_fmt.imm_11_0[11]}},
                         instr_i.i_fmt.imm_11_0};
            end
            IMM_S: begin
                imm_o = {{(`XLEN-12){instr_i.s_fmt.imm_11_5[6]}},
                         instr_i.s_fmt.imm_11_5,
                         instr_i.s_fmt.imm_4_0};
            end
            IMM_B: begin
                imm_o = {{(`XLEN-12){instr_i.b_fmt.imm_12}},
                         instr_i.b_fmt.imm_11,
                         instr_i.b_fmt.imm_10_5,
                         instr_i.b_fmt.imm_4_1,
                         1'b0};                      // halfword aligned
            end
            IMM_U: begin
                imm_o = {instr_i.u_fmt.imm_31_12, 12'b0};
            end
            IMM_J: begin
                imm_o = {{(`XLEN-20){instr_i.j_fmt.imm_20}},
                         instr_i.j_fmt.imm_19_12,
                         instr_i.j_fmt.imm_11,
                         instr_i.j_fmt.imm_10_1,
                         1'b0};
            end
            default: imm_o = '0;                     // register ops carry no imm
        endcase
    end

    // shift amount sits in the low bits of the i-type immediate
    assign shamt_o = (fmt_i == IMM_SHAMT) ? instr_i.i_fmt.imm_11_0[`SHAMT_W-1:0] : '0;

endmodule

// File: rtl/int_reg_file.sv
// ======================================================================
// integer register file, two read ports and one write port
// ======================================================================
`include "decode_defs.svh"

module int_reg_file (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  logic                   we_i,
    input  logic [`REG_ADDR_W-1:0] waddr_i,
    input  logic [`XLEN-1:0]       wdata_i,
    input  logic [`REG_ADDR_W-1:0] raddr1_i,
    input  logic [`REG_ADDR_W-1:0] raddr2_i,
    output logic [`XLEN-1:0]       rdata1_o,
    output logic [`XLEN-1:0]       rdata2_o
);

    logic [`XLEN-1:0] regs [`NUM_REGS];

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin  // x0 stays zero
            regs[waddr_i] <= wdata_i;
        end
    end

    // reads see the value before a same-cycle write
    assign rdata1_o = regs[raddr1_i];
    assign rdata2_o = regs[raddr2_i];

    x0_reads_zero: assert property (
        @(posedge clk_i) disable iff (rst_i)
        (raddr1_i != '0 || rdata1_o == '0) && (raddr2_i != '0 || rdata2_o == '0)
    ) else $error("x0 read returned a nonzero value");

endmodule

// File: rtl/decode_stage.sv
// ======================================================================
// decode stage top with decoder, immediate generator, register file
// and the output register toward execute
// ======================================================================
`include "decode_defs.svh"

module decode_stage import decode_pkg::*; (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  logic                   enable_i,
    input  logic                   stall_i,
    input  logic [`XLEN-1:0]       instr_i,
    input  logic [`XLEN-1:0]       pc_i,
    input  logic                   wb_en_i,
    input  logic [`REG_ADDR_W-1:0] wb_addr_i,
    input  logic [`XLEN-1:0]       wb_data_i,
    output logic                   valid_o,
    output logic                   illegal_o,
    output unit_e                  unit_o,
    output op_e                    op_o,
    output logic [`XLEN-1:0]       imm_o,
    output logic [`SHAMT_W-1:0]    shamt_o,
    output logic [`XLEN-1:0]       rs1_data_o,
    output logic [`XLEN-1:0]       rs2_data_o,
    output logic [`REG_ADDR_W-1:0] rd_o,
    output logic [`XLEN-1:0]       pc_o
);

    instr_u                word;
    unit_e                 unit_d;
    op_e                   op_d;
    imm_fmt_e              fmt_d;
    logic                  illegal_d;
    logic [`XLEN-1:0]      imm_d;
    logic [`SHAMT_W-1:0]   shamt_d;
    logic [`XLEN-1:0]      rs1_d;
    logic [`XLEN-1:0]      rs2_d;

    assign word = instr_i;

    op_decoder u_op_decoder (
        .instr_i   (word),
        .unit_o    (unit_d),
        .op_o      (op_d),
        .imm_fmt_o (fmt_d),
        .illegal_o (illegal_d)
    );

    imm_gen u_imm_gen (
        .instr_i (word),
        .fmt_i   (fmt_d),
        .imm_o   (imm_d),
        .shamt_o (shamt_d)
    );

    int_reg_file u_int_reg_file (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .we_i     (wb_en_i),
        .waddr_i  (wb_addr_i),
        .wdata_i  (wb_data_i),
        .raddr1_i (word.r_fmt.rs1),
        .raddr2_i (word.r_fmt.rs2),
        .rdata1_o (rs1_d),
        .rdata2_o (rs2_d)
    );

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_o    <= 1'b0;
            illegal_o  <= 1'b0;
            unit_o     <= UNIT_ALU;
            op_o       <= OP_ADD;
            imm_o      <= '0;
            shamt_o    <= '0;
            rs1_data_o <= '0;
            rs2_data_o <= '0;
            rd_o       <= '0;
            pc_o       <= '0;
        end else if (!stall_i) begin        // stall freezes everything
            valid_o <= enable_i;
            if (enable_i) begin
                illegal_o  <= illegal_d;
                unit_o     <= unit_d;
                op_o       <= op_d;
                imm_o      <= imm_d;
                shamt_o    <= shamt_d;
                rs1_data_o <= rs1_d;
                rs2_data_o <= rs2_d;
                rd_o       <= word.r_fmt.rd;
                pc_o       <= pc_i;
            end
        end
    end

    stall_holds: assert property (
        @(posedge clk_i) disable iff (rst_i)
        stall_i |=> $stable(valid_o) && $stable(illegal_o) && $stable(unit_o) &&
                    $stable(op_o) && $stable(imm_o) && $stable(shamt_o) &&
                    $stable(rs1_data_o) && $stable(rs2_data_o) && $stable(rd_o) &&
                    $stable(pc_o)
    ) else $error("decode outputs changed during a stall");

    no_valid_after_reset: assert property (
        @(posedge clk_i) rst_i |=> !valid_o
    ) else $error("valid_o set in the cycle after reset");

endmodule

// File: testbench/tb_decode_stage.sv
// ======================================================================
// decode stage testbench with shadow register file, expected decode
// model, output assertions and cycle timeout
// ======================================================================
`include "decode_defs.svh"

module tb_decode_stage import decode_pkg::*; ();

    // whole sequence runs about 330 cycles
    localparam int TIMEOUT_CYCLES = 2000;

    typedef struct packed {
        logic                illegal;
        unit_e               unit;
        op_e                 op;
        logic [`XLEN-1:0]    imm;
        logic [`SHAMT_W-1:0] shamt;
    } dec_t;

    // operation per funct3, unused slots hold add
    localparam op_e R_OPS  [8] = '{OP_ADD, OP_SLL, OP_SLT, OP_SLTU,
                                   OP_XOR, OP_SRL, OP_OR, OP_AND};
    localparam op_e I_OPS  [8] = '{OP_ADDI, OP_SLLI, OP_SLTI, OP_SLTIU,
                                   OP_XORI, OP_SRLI, OP_ORI, OP_ANDI};
    localparam op_e MD_OPS [8] = '{OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU,
                                   OP_DIV, OP_DIVU, OP_REM, OP_REMU};
    localparam op_e BR_OPS [8] = '{OP_BEQ, OP_BNE, OP_ADD, OP_ADD,
                                   OP_BLT, OP_BGE, OP_BLTU, OP_BGEU};
    localparam op_e LD_OPS [8] = '{OP_LB, OP_LH, OP_LW, OP_ADD,
                                   OP_LBU, OP_LHU, OP_ADD, OP_ADD};
    localparam op_e ST_OPS [8] = '{OP_SB, OP_SH, OP_SW, OP_ADD,
                                   OP_ADD, OP_ADD, OP_ADD, OP_ADD};

    logic                   clk_i = 1'b0;
    logic                   rst_i;
    logic                   enable_i;
    logic                   stall_i;
    logic [`XLEN-1:0]       instr_i;
    logic [`XLEN-1:0]       pc_i;
    logic                   wb_en_i;
    logic [`REG_ADDR_W-1:0] wb_addr_i;
    logic [`XLEN-1:0]       wb_data_i;
    logic                   valid_o;
    logic                   illegal_o;
    unit_e                  unit_o;
    op_e                    op_o;
    logic [`XLEN-1:0]       imm_o;
    logic [`SHAMT_W-1:0]    shamt_o;
    logic [`XLEN-1:0]       rs1_data_o;
    logic [`XLEN-1:0]       rs2_data_o;
    logic [`REG_ADDR_W-1:0] rd_o;
    logic [`XLEN-1:0]       pc_o;

    integer                 seed = 32'ha7c6;
    int                     cycle_count = 0;
    logic [`XLEN-1:0]       shadow [`NUM_REGS];
    logic                   exp_valid;
    dec_t                   exp_dec;
    logic [`XLEN-1:0]       exp_rs1;
    logic [`XLEN-1:0]       exp_rs2;
    logic [`REG_ADDR_W-1:0] exp_rd;
    logic [`XLEN-1:0]       exp_pc;

    decode_stage DUT (.*);

    always #2 clk_i = ~clk_i;

    function automatic logic [`XLEN-1:0] rand32();
        return $random(seed);
    endfunction

    // decode rules of RV32IM as the stage should apply them
    function automatic dec_t expected_decode(input logic [`XLEN-1:0] w);
        dec_t       d;
        imm_fmt_e   fmt;
        logic [2:0] f3;
        logic [6:0] f7;
        f3        = w[14:12];
        f7        = w[31:25];
        d.illegal = 1'b0;
        d.unit    = UNIT_ALU;
        d.op      = OP_ADD;
        fmt       = IMM_NONE;
        case (w[6:0])
            `OPC_OP: begin
                if (f7 == `FUNCT7_MULDIV) begin
                    d.op   = MD_OPS[f3];
                    d.unit = (d.op inside {OP_DIV, OP_DIVU, OP_REM, OP_REMU}) ?
                             UNIT_DIV : UNIT_MUL;
                end else if (f7 == `FUNCT7_BASE) begin
                    d.op = R_OPS[f3];
                end else if (f7 == `FUNCT7_ALT && f3 == `F3_ADD) begin
                    d.op = OP_SUB;
                end else if (f7 == `FUNCT7_ALT && f3 == `F3_SR) begin
                    d.op = OP_SRA;
                end else begin
                    d.illegal = 1'b1;
                end
            end
            `OPC_OP_IMM: begin
                d.op = I_OPS[f3];
                fmt  = IMM_I;
                if (f3 == `F3_SLL || f3 == `F3_SR) begin  // imm[11:5] acts as funct7
                    fmt = IMM_SHAMT;
                    if (f3 == `F3_SR && f7 == `FUNCT7_ALT) begin
                        d.op = OP_SRAI;
                    end else begin
                        d.illegal = (f7 != `FUNCT7_BASE);
                    end
                end
            end
            `OPC_LOAD: begin
                d.unit    = UNIT_MEM;
                d.op      = LD_OPS[f3];
                fmt       = IMM_I;
                d.illegal = (f3 == 3'd3 || f3 > 3'd5);
            end
            `OPC_STORE: begin
                d.unit    = UNIT_MEM;
                d.op      = ST_OPS[f3];
                fmt       = IMM_S;
                d.illegal = (f3 > 3'd2);
            end
            `OPC_BRANCH: begin
                d.unit    = UNIT_BRANCH;
                d.op      = BR_OPS[f3];
                fmt       = IMM_B;
                d.illegal = (f3 == 3'd2 || f3 == 3'd3);
            end
            `OPC_JAL: begin
                d.unit = UNIT_BRANCH;
                d.op   = OP_JAL;
                fmt    = IMM_J;
            end
            `OPC_JALR: begin
                d.unit    = UNIT_BRANCH;
                d.op      = OP_JALR;
                fmt       = IMM_I;
                d.illegal = (f3 != 3'd0);
            end
            `OPC_LUI: begin
                d.op = OP_LUI;
                fmt  = IMM_U;
            end
            `OPC_AUIPC: begin
                d.op = OP_AUIPC;
                fmt  = IMM_U;
            end
            default: d.illegal = 1'b1;
        endcase
        if (d.illegal) begin
            d.unit = UNIT_ALU;
            d.op   = OP_ADD;
            fmt    = IMM_NONE;
        end
        case (fmt)
            IMM_I, IMM_SHAMT: d.imm = {{20{w[31]}}, w[31:20]};
            IMM_S:            d.imm = {{20{w[31]}}, w[31:25], w[11:7]};
            IMM_B:            d.imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            IMM_U:            d.imm = {w[31:12], 12'b0};
            IMM_J:            d.imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            default:          d.imm = '0;
        endcase
        d.shamt = (fmt == IMM_SHAMT) ? w[24:20] : '0;
        return d;
    endfunction

    // expected output register, same accept and stall rule as the stage
    always @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                shadow[i] <= '0;
            end
            exp_valid       <= 1'b0;
            exp_dec.illegal <= 1'b0;
            exp_dec.unit    <= UNIT_ALU;
            exp_dec.op      <= OP_ADD;
            exp_dec.imm     <= '0;
            exp_dec.shamt   <= '0;
            exp_rs1         <= '0;
            exp_rs2         <= '0;
            exp_rd          <= '0;
            exp_pc          <= '0;
        end else begin
            if (wb_en_i && wb_addr_i != 5'd0) begin
                shadow[wb_addr_i] <= wb_data_i;
            end
            if (!stall_i) begin
                exp_valid <= enable_i;
                if (enable_i) begin
                    exp_dec <= expected_decode(instr_i);
                    exp_rs1 <= shadow[instr_i[19:15]];  // old value on same-cycle write
                    exp_rs2 <= shadow[instr_i[24:20]];
                    exp_rd  <= instr_i[11:7];
                    exp_pc  <= pc_i;
                end
            end
        end
    end

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("** Error: time %0t, %s expected %h, actual %h", $time, name, expected,
                 actual);
        $display("TESTBENCH FAILED");
        $fatal(1, "stopped at first mismatch");
    endtask

    check_valid: assert property (@(posedge clk_i) disable iff (rst_i) valid_o == exp_valid)
        else report_mismatch("valid_o", 32'($sampled(exp_valid)), 32'($sampled(valid_o)));
    check_illegal: assert property (@(posedge clk_i) disable iff (rst_i)
        illegal_o == exp_dec.illegal)
        else report_mismatch("illegal_o", 32'($sampled(exp_dec.illegal)),
                             32'($sampled(illegal_o)));
    check_unit: assert property (@(posedge clk_i) disable iff (rst_i) unit_o == exp_dec.unit)
        else report_mismatch("unit_o", 32'($sampled(exp_dec.unit)), 32'($sampled(unit_o)));
    check_op: assert property (@(posedge clk_i) disable iff (rst_i) op_o == exp_dec.op)
        else report_mismatch("op_o", 32'($sampled(exp_dec.op)), 32'($sampled(op_o)));
    check_imm: assert property (@(posedge clk_i) disable iff (rst_i) imm_o == exp_dec.imm)
        else report_mismatch("imm_o", $sampled(exp_dec.imm), $sampled(imm_o));
    check_shamt: assert property (@(posedge clk_i) disable iff (rst_i)
        shamt_o == exp_dec.shamt)
        else report_mismatch("shamt_o", 32'($sampled(exp_dec.shamt)), 32'($sampled(shamt_o)));
    check_rs1: assert property (@(posedge clk_i) disable iff (rst_i) rs1_data_o == exp_rs1)
        else report_mismatch("rs1_data_o", $sampled(exp_rs1), $sampled(rs1_data_o));
    check_rs2: assert property (@(posedge clk_i) disable iff (rst_i) rs2_data_o == exp_rs2)
        else report_mismatch("rs2_data_o", $sampled(exp_rs2), $sampled(rs2_data_o));
    check_rd: assert property (@(posedge clk_i) disable iff (rst_i) rd_o == exp_rd)
        else report_mismatch("rd_o", 32'($sampled(exp_rd)), 32'($sampled(rd_o)));
    check_pc: assert property (@(posedge clk_i) disable iff (rst_i) pc_o == exp_pc)
        else report_mismatch("pc_o", $sampled(exp_pc), $sampled(pc_o));

    always @(posedge clk_i) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == TIMEOUT_CYCLES) begin
            $display("timeout: the test sequence did not finish in %0d cycles",
                     TIMEOUT_CYCLES);
            $display("TESTBENCH FAILED");
            $fatal(1, "timeout");
        end
    end

    task automatic next_cycle();
        @(posedge clk_i);
        #1;
    endtask

    task automatic write_reg(input logic [4:0] addr, input logic [31:0] data);
        wb_en_i   = 1'b1;
        wb_addr_i = addr;
        wb_data_i = data;
        next_cycle();
        wb_en_i   = 1'b0;
    endtask

    // random word with the chosen opcode and optional funct3/funct7
    task automatic send_instr(input logic [6:0] opc, input logic [2:0] f3,
                              input logic [6:0] f7, input bit keep_f3, input bit keep_f7);
        logic [31:0] w;
        logic [31:0] pc;
        w      = rand32();
        pc     = rand32();
        w[6:0] = opc;
        if (keep_f3) begin
            w[14:12] = f3;
        end
        if (keep_f7) begin
            w[31:25] = f7;
        end
        instr_i  = w;
        pc_i     = {pc[31:2], 2'b00};
        enable_i = 1'b1;
        stall_i  = 1'b0;
        next_cycle();
    endtask

    initial begin
        logic [31:0] r;
        rst_i     = 1'b1;
        enable_i  = 1'b0;
        stall_i   = 1'b0;
        instr_i   = '0;
        pc_i      = '0;
        wb_en_i   = 1'b0;
        wb_addr_i = '0;
        wb_data_i = '0;
        repeat (5) next_cycle();
        rst_i = 1'b0;

        // add x1, x0, x0 right after reset reads x0
        instr_i  = {7'd0, 5'd0, 5'd0, 3'd0, 5'd1, `OPC_OP};
        enable_i = 1'b1;
        next_cycle();
        enable_i = 1'b0;

        write_reg(5'd0, 32'hdead_beef);
        for (int i = 0; i < 40; i++) begin
            r = rand32();
            write_reg(r[4:0], rand32());
        end

        // x0 must still read zero after the write aimed at it
        instr_i  = {7'd0, 5'd0, 5'd0, 3'd0, 5'd2, `OPC_OP};
        enable_i = 1'b1;
        next_cycle();
        enable_i = 1'b0;

        for (int i = 0; i < 30; i++) begin
            send_instr(`OPC_OP, 3'd0, `FUNCT7_BASE, 1'b0, 1'b1);
        end

        for (int f = 0; f < 8; f++) begin
            send_instr(`OPC_OP, f[2:0], `FUNCT7_BASE, 1'b1, 1'b1);
            send_instr(`OPC_OP, f[2:0], `FUNCT7_MULDIV, 1'b1, 1'b1);
            send_instr(`OPC_OP_IMM, f[2:0], `FUNCT7_BASE, 1'b1, f == 1 || f == 5);
            if (f != 3 && f < 6) begin
                send_instr(`OPC_LOAD, f[2:0], 7'd0, 1'b1, 1'b0);
            end
            if (f < 3) begin
                send_instr(`OPC_STORE, f[2:0], 7'd0, 1'b1, 1'b0);
            end
            if (f != 2 && f != 3) begin
                send_instr(`OPC_BRANCH, f[2:0], 7'd0, 1'b1, 1'b0);
            end
        end
        send_instr(`OPC_OP, `F3_ADD, `FUNCT7_ALT, 1'b1, 1'b1);
        send_instr(`OPC_OP, `F3_SR, `FUNCT7_ALT, 1'b1, 1'b1);
        send_instr(`OPC_OP_IMM, `F3_SR, `FUNCT7_ALT, 1'b1, 1'b1);
        send_instr(`OPC_JAL, 3'd0, 7'd0, 1'b0, 1'b0);
        send_instr(`OPC_JALR, `F3_JALR, 7'd0, 1'b1, 1'b0);
        send_instr(`OPC_LUI, 3'd0, 7'd0, 1'b0, 1'b0);
        send_instr(`OPC_AUIPC, 3'd0, 7'd0, 1'b0, 1'b0);

        // unused opcode, then an OP word with an unknown funct7
        send_instr(7'b1111111, 3'd0, 7'd0, 1'b0, 1'b0);
        send_instr(`OPC_OP, 3'd0, 7'b1111111, 1'b0, 1'b1);

        for (int i = 0; i < 200; i++) begin
            r         = rand32();
            instr_i   = rand32();
            pc_i      = {r[31:12], 12'h000};
            enable_i  = r[0] | r[1];
            stall_i   = r[2] & r[3];
            wb_en_i   = r[4];
            wb_addr_i = r[9:5];
            wb_data_i = rand32();
            next_cycle();
        end
        enable_i = 1'b0;
        stall_i  = 1'b0;
        wb_en_i  = 1'b0;
        repeat (3) next_cycle();

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// File: vlog.f
+incdir+rtl
rtl/decode_pkg.sv
rtl/op_decoder.sv
rtl/imm_gen.sv
rtl/int_reg_file.sv
rtl/decode_stage.sv
testbench/tb_decode_stage.sv

// File: run.sh
#!/bin/sh
# compile and run the decode stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module tb_decode_stage -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vtb_decode_stage)
sim_status=$?
echo "$sim_out"

if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -q "^TESTBENCH PASSED$"; then
    exit 0
else
    echo "pass message not found in simulation output"
    exit 1
fi
